// File: sim.f
+incdir+hw
hw/mboxPkg.sv
hw/phaseClock.sv
hw/memStartCtl.sv
hw/coreWordSeq.sv
hw/diagMux.sv
hw/mbox.sv
sim/mboxCheck.sv
sim/mboxTb.sv

// File: run.sh
#!/bin/sh
# Build and run the mbox testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module mboxTb -o mboxTb

out=$(./obj_dir/mboxTb)
echo "$out"
echo "$out" | grep -qx "No errors"

// File: sim/mboxTb.sv
module mboxTb
  import mboxPkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic     rd;
    logic     wr;
    rqBits_t  rq;
    wordAdr_t adr;
    logic     bad;
    logic     nxm;
    logic     par;
  } txn_t;

  localparam int Rows = 6;
  // Cycles allowed per table row, on top of a fixed margin
  localparam int RowBudget = 64;
  localparam int CycleLimit = Rows * RowBudget + 100;

  // rd, wr, rq, adr, forceBadPar, useNxm, expected parity
  localparam txn_t Txns [Rows] = '{
    '{1'b1, 1'b0, 4'b1111, 2'd0, 1'b0, 1'b0, 1'b0},
    '{1'b0, 1'b1, 4'b0011, 2'd2, 1'b0, 1'b0, 1'b1},
    '{1'b1, 1'b0, 4'b0110, 2'd3, 1'b1, 1'b0, 1'b1},
    '{1'b1, 1'b0, 4'b1000, 2'd1, 1'b0, 1'b1, 1'b0},
    '{1'b0, 1'b1, 4'b1010, 2'd1, 1'b1, 1'b1, 1'b0},
    '{1'b1, 1'b0, 4'b0101, 2'd2, 1'b0, 1'b0, 1'b1}
  };

  logic clk = 1'b0;
  logic arstN;
  logic startReq, rdReq, wrReq, forceBadPar;
  logic memAcknA, memAcknB, nxmAckn, memDataValA, memDataValB;
  logic diagEn;
  logic [2:0] diagSel = 3'd0;
  rqBits_t rqIn, expRq, memRq;
  wordAdr_t sbusAdr, coreAdr;
  logic expPar;
  logic memStartA, memStartB, lastAckn, memAdrPar;
  logic coreDataValid, coreRdInProg, aChangeComing, bChangeComing;
  diagWord_t ebusData;
  int cycles = 0;

  always #2 clk = ~clk;

  mbox DUT (
    .clk(clk), .arstN(arstN), .startReq(startReq), .rdReq(rdReq), .wrReq(wrReq),
    .forceBadPar(forceBadPar), .memAcknA(memAcknA), .memAcknB(memAcknB),
    .nxmAckn(nxmAckn), .rqIn(rqIn), .sbusAdr(sbusAdr), .memDataValA(memDataValA),
    .memDataValB(memDataValB), .diagEn(diagEn), .diagSel(diagSel),
    .memStartA(memStartA), .memStartB(memStartB), .memRq(memRq), .lastAckn(lastAckn),
    .memAdrPar(memAdrPar), .coreDataValid(coreDataValid), .coreAdr(coreAdr),
    .coreRdInProg(coreRdInProg), .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing), .ebusData(ebusData)
  );

  mboxCheck check (
    .clk(clk), .arstN(arstN), .startReq(startReq), .rdReq(rdReq),
    .forceBadPar(forceBadPar), .memAcknA(memAcknA), .memAcknB(memAcknB),
    .nxmAckn(nxmAckn), .memDataValA(memDataValA), .memDataValB(memDataValB),
    .diagEn(diagEn), .diagSel(diagSel), .rqIn(rqIn), .sbusAdr(sbusAdr),
    .expRq(expRq), .expPar(expPar), .memStartA(memStartA), .memStartB(memStartB),
    .memRq(memRq), .lastAckn(lastAckn), .memAdrPar(memAdrPar),
    .coreDataValid(coreDataValid), .coreAdr(coreAdr), .coreRdInProg(coreRdInProg),
    .aChangeComing(aChangeComing), .bChangeComing(bChangeComing), .ebusData(ebusData)
  );

  // Readback walks through all rows while traffic runs
  always @(posedge clk) begin
    diagSel <= diagSel + 3'd1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("Errors found");
      $finish;
    end
  end

  task automatic waitStrobe(input logic useA);
    do begin
      @(negedge clk);
    end while (!(useA ? aChangeComing : bChangeComing));
  endtask

  task automatic setAck(input logic useA, input logic nxm, input logic dv, input logic val);
    if (nxm) begin
      nxmAckn <= val;
    end else if (useA) begin
      memAcknA <= val;
    end else begin
      memAcknB <= val;
    end
    if (dv && useA) begin
      memDataValA <= val;
    end else if (dv) begin
      memDataValB <= val;
    end
  endtask

  task automatic runTxn(input txn_t t);
    int   nWords;
    int   skip;
    logic useA;
    @(posedge clk);
    startReq <= 1'b1;
    rdReq <= t.rd;
    wrReq <= t.wr;
    rqIn <= t.rq;
    sbusAdr <= t.adr;
    forceBadPar <= t.bad;
    expRq <= t.rq;
    expPar <= t.par;
    @(negedge clk);
    while (!(memStartA || memStartB)) begin
      @(negedge clk);
    end
    useA = memStartA;
    nWords = $countones(t.rq);
    @(posedge clk);
    startReq <= 1'b0;
    for (int w = 0; w < nWords; w++) begin
      skip = int'($urandom_range(2, 0));
      repeat (skip) waitStrobe(useA);
      @(posedge clk);
      setAck(useA, t.nxm, t.rd, 1'b1);
      waitStrobe(useA);
      @(posedge clk);
      setAck(useA, t.nxm, t.rd, 1'b0);
    end
    // A stray acknowledge after the last word must not count
    @(posedge clk);
    setAck(useA, t.nxm, 1'b0, 1'b1);
    @(negedge clk);
    while (memStartA || memStartB) begin
      @(negedge clk);
    end
    @(posedge clk);
    setAck(useA, t.nxm, 1'b0, 1'b0);
    @(negedge clk);
    while (coreRdInProg || coreDataValid) begin
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'h5d58_6653));
    arstN = 1'b0;
    startReq = 1'b0;
    rdReq = 1'b0;
    wrReq = 1'b0;
    forceBadPar = 1'b0;
    memAcknA = 1'b0;
    memAcknB = 1'b0;
    nxmAckn = 1'b0;
    memDataValA = 1'b0;
    memDataValB = 1'b0;
    diagEn = 1'b0;
    rqIn = '0;
    sbusAdr = '0;
    expRq = '0;
    expPar = 1'b0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    diagEn <= 1'b1;
    for (int i = 0; i < Rows; i++) begin
      runTxn(Txns[i]);
    end
    @(posedge clk);
    diagEn <= 1'b0;
    repeat (10) @(posedge clk);
    $display("Check summary: %0d errors", check.errCount);
    if (check.errCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sim/mboxCheck.sv
module mboxCheck
  import mboxPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      startReq,
  input  logic      rdReq,
  input  logic      forceBadPar,
  input  logic      memAcknA,
  input  logic      memAcknB,
  input  logic      nxmAckn,
  input  logic      memDataValA,
  input  logic      memDataValB,
  input  logic      diagEn,
  input  logic [2:0] diagSel,
  input  rqBits_t   rqIn,
  input  wordAdr_t  sbusAdr,
  input  rqBits_t   expRq,
  input  logic      expPar,
  input  logic      memStartA,
  input  logic      memStartB,
  input  rqBits_t   memRq,
  input  logic      lastAckn,
  input  logic      memAdrPar,
  input  logic      coreDataValid,
  input  wordAdr_t  coreAdr,
  input  logic      coreRdInProg,
  input  logic      aChangeComing,
  input  logic      bChangeComing,
  input  diagWord_t ebusData
);

  timeunit 1ns;
  timeprecision 100ps;

  int errCount = 0;

  // Reference state, advanced once per cycle
  logic [2:0] phaseCnt;
  logic       mA;
  logic       mB;
  logic       done;
  int         acks;
  rqBits_t    hRq;
  wordAdr_t   hAdr;
  logic       hRd;
  logic       hPar;
  logic       loadQ;
  logic       p1;
  logic       cdv;
  wordAdr_t   adr;
  int         words;
  logic       inProg;

  task automatic checkVal(input string name, input logic [7:0] expV, input logic [7:0] actV);
    if (expV !== actV) begin
      errCount++;
      $display("** Error: %s expected %h actual %h at %0t", name, expV, actV, $time);
    end
  endtask

  always @(negedge clk) begin : compareStep
    logic      strobeA;
    logic      strobeB;
    logic      ackNow;
    logic      expLast;
    logic      dv2;
    logic      take;
    logic      clrA;
    logic      clrB;
    diagWord_t rows [8];
    diagWord_t expEbus;
    if (!arstN) begin
      phaseCnt = '0;
      mA = 1'b0;
      mB = 1'b0;
      done = 1'b0;
      acks = 0;
      hRq = '0;
      hAdr = '0;
      hRd = 1'b0;
      // Held values are all zero, so odd parity is one
      hPar = 1'b1;
      loadQ = 1'b0;
      p1 = 1'b0;
      cdv = 1'b0;
      adr = '0;
      words = 0;
      inProg = 1'b0;
      checkVal("memStartA", 8'h00, 8'(memStartA));
      checkVal("memStartB", 8'h00, 8'(memStartB));
      checkVal("memRq", 8'h00, 8'(memRq));
      checkVal("lastAckn", 8'h00, 8'(lastAckn));
      checkVal("coreDataValid", 8'h00, 8'(coreDataValid));
      checkVal("coreRdInProg", 8'h00, 8'(coreRdInProg));
      checkVal("ebusData", 8'h00, ebusData);
    end else begin
      strobeA = (phaseCnt == 3'd7);
      strobeB = (phaseCnt == 3'd3);
      ackNow = !done && ((mA && strobeA && (memAcknA || nxmAckn)) ||
                         (mB && strobeB && (memAcknB || nxmAckn)));
      expLast = ackNow && (acks + 1 == $countones(hRq));
      dv2 = (mA || mB) && hRd &&
            ((memDataValA && strobeA) || (memDataValB && strobeB));

      checkVal("aChangeComing", 8'(strobeA), 8'(aChangeComing));
      checkVal("bChangeComing", 8'(strobeB), 8'(bChangeComing));
      checkVal("memStartA", 8'(mA), 8'(memStartA));
      checkVal("memStartB", 8'(mB), 8'(memStartB));
      checkVal("lastAckn", 8'(expLast), 8'(lastAckn));
      checkVal("coreDataValid", 8'(cdv), 8'(coreDataValid));
      checkVal("coreAdr", 8'(adr), 8'(coreAdr));
      checkVal("coreRdInProg", 8'(inProg), 8'(coreRdInProg));
      if (mA || mB) begin
        checkVal("memRq", 8'(expRq), 8'(memRq));
        checkVal("memAdrPar", 8'(expPar), 8'(memAdrPar));
      end

      // Readback rows as the bus should present them
      rows[0] = {2'b00, hRq, hAdr};
      rows[1] = {5'b0, mA, mB, expLast};
      rows[2] = {5'b0, dv2, p1, cdv};
      rows[3] = {5'b0, adr, inProg};
      rows[4] = {5'b0, phaseCnt[2], strobeA, strobeB};
      rows[5] = {6'b0, hPar, forceBadPar};
      rows[6] = '0;
      rows[7] = '0;
      expEbus = diagEn ? rows[diagSel] : 8'h00;
      checkVal("ebusData", expEbus, ebusData);

      take = startReq && !(mA || mB) && (strobeA || strobeB);
      clrA = mA && strobeA && done;
      clrB = mB && strobeB && done;

      // Core side sees the held request one cycle after the start
      if (loadQ) begin
        adr = hAdr;
        words = $countones(hRq);
        inProg = (mA || mB) && hRd;
      end else if (cdv) begin
        adr = adr + wordAdr_t'(1);
        if (words != 0) begin
          if (words == 1) begin
            inProg = 1'b0;
          end
          words--;
        end
      end
      cdv = p1;
      p1 = dv2;
      loadQ = take;

      if (clrA || clrB) begin
        done = 1'b0;
      end else if (expLast) begin
        done = 1'b1;
      end
      if (take) begin
        acks = 0;
        hRq = rqIn;
        hAdr = sbusAdr;
        hRd = rdReq;
        hPar = expPar;
      end else if (ackNow) begin
        acks++;
      end
      if (take && strobeA) begin
        mA = 1'b1;
      end else if (clrA) begin
        mA = 1'b0;
      end
      if (take && strobeB) begin
        mB = 1'b1;
      end else if (clrB) begin
        mB = 1'b0;
      end
      phaseCnt = phaseCnt + 3'd1;
    end
  end

endmodule

// File: hw/mbox.sv
`include "mbox_defines.svh"

module mbox
  import mboxPkg::*;
(
  input  logic                                clk,
  input  logic                                arstN,
  input  logic                                startReq,
  input  logic                                rdReq,
  input  logic                                wrReq,
  input  logic                                forceBadPar,
  input  logic                                memAcknA,
  input  logic                                memAcknB,
  input  logic                                nxmAckn,
  input  rqBits_t                             rqIn,
  input  wordAdr_t                            sbusAdr,
  input  logic                                memDataValA,
  input  logic                                memDataValB,
  input  logic                                diagEn,
  input  logic [$clog2(`MBOX_DIAG_ROWS)-1:0] diagSel,
  output logic                                memStartA,
  output logic                                memStartB,
  output rqBits_t                             memRq,
  output logic                                lastAckn,
  output logic                                memAdrPar,
  output logic                                coreDataValid,
  output wordAdr_t                            coreAdr,
  output logic                                coreRdInProg,
  output logic                                aChangeComing,
  output logic                                bChangeComing,
  output diagWord_t                           ebusData
);

  busPhase_t curPhase;
  logic      memStartRd;
  logic      loadRq;
  wordAdr_t  heldAdr;
  logic      dataValMinus2;
  logic      dataValMinus1;
  diagWord_t statusRows [`MBOX_DIAG_ROWS];

  phaseClock uPhaseClock (
    .clk(clk), .arstN(arstN), .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing), .curPhase(curPhase)
  );

  memStartCtl uMemStartCtl (
    .clk(clk), .arstN(arstN), .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing), .startReq(startReq), .rdReq(rdReq),
    .wrReq(wrReq), .forceBadPar(forceBadPar), .memAcknA(memAcknA),
    .memAcknB(memAcknB), .nxmAckn(nxmAckn), .rqIn(rqIn), .sbusAdr(sbusAdr),
    .memStartA(memStartA), .memStartB(memStartB), .memStartRd(memStartRd),
    .loadRq(loadRq), .lastAckn(lastAckn), .memAdrPar(memAdrPar),
    .heldRq(memRq), .heldAdr(heldAdr)
  );

  coreWordSeq uCoreWordSeq (
    .clk(clk), .arstN(arstN), .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing), .memStartRd(memStartRd), .loadRq(loadRq),
    .memDataValA(memDataValA), .memDataValB(memDataValB), .heldRq(memRq),
    .heldAdr(heldAdr), .coreDataValid(coreDataValid),
    .coreRdInProg(coreRdInProg), .coreAdr(coreAdr),
    .dataValMinus2(dataValMinus2), .dataValMinus1(dataValMinus1)
  );

  // Readback rows, low bits first
  assign statusRows[0] = {2'b00, memRq, heldAdr};
  assign statusRows[1] = {5'b0, memStartA, memStartB, lastAckn};
  assign statusRows[2] = {5'b0, dataValMinus2, dataValMinus1, coreDataValid};
  assign statusRows[3] = {5'b0, coreAdr, coreRdInProg};
  assign statusRows[4] = {5'b0, curPhase, aChangeComing, bChangeComing};
  assign statusRows[5] = {6'b0, memAdrPar, forceBadPar};
  assign statusRows[6] = '0;
  assign statusRows[7] = '0;

  diagMux uDiagMux (
    .diagEn(diagEn), .diagSel(diagSel), .statusRows(statusRows), .ebusData(ebusData)
  );

endmodule

// File: hw/diagMux.sv
`include "mbox_defines.svh"

module diagMux
  import mboxPkg::*;
(
  input  logic                                diagEn,
  input  logic [$clog2(`MBOX_DIAG_ROWS)-1:0] diagSel,
  input  diagWord_t                           statusRows [`MBOX_DIAG_ROWS],
  output diagWord_t                           ebusData
);

  // Bus lines stay quiet unless a diagnostic read is in progress
  always_comb begin
    if (diagEn) begin
      ebusData = statusRows[diagSel];
    end else begin
      ebusData = '0;
    end
  end

endmodule

// File: hw/coreWordSeq.sv
`include "mbox_defines.svh"

module coreWordSeq
  import mboxPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  logic     aChangeComing,
  input  logic     bChangeComing,
  input  logic     memStartRd,
  input  logic     loadRq,
  input  logic     memDataValA,
  input  logic     memDataValB,
  input  rqBits_t  heldRq,
  input  wordAdr_t heldAdr,
  output logic     coreDataValid,
  output logic     coreRdInProg,
  output wordAdr_t coreAdr,
  output logic     dataValMinus2,
  output logic     dataValMinus1
);

  localparam int CntW = $clog2(`MBOX_WORDS + 1);

  logic [CntW-1:0] wordsLeft;

  // Number of words asked for in a request
  function automatic logic [CntW-1:0] countRq(rqBits_t rq);
    logic [CntW-1:0] n;
    n = '0;
    for (int i = 0; i < `MBOX_WORDS; i++) begin
      n = n + CntW'(rq[i]);
    end
    return n;
  endfunction

  // Data valid is sampled on the strobe of its phase
  assign dataValMinus2 = memStartRd &
      ((memDataValA & aChangeComing) | (memDataValB & bChangeComing));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      dataValMinus1 <= 1'b0;
      coreDataValid <= 1'b0;
    end else begin
      dataValMinus1 <= dataValMinus2;
      coreDataValid <= dataValMinus1;
    end
  end

  // Word address wraps within the quad
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      coreAdr <= '0;
    end else if (loadRq) begin
      coreAdr <= heldAdr;
    end else if (coreDataValid) begin
      coreAdr <= coreAdr + wordAdr_t'(1);
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wordsLeft <= '0;
      coreRdInProg <= 1'b0;
    end else if (loadRq) begin
      wordsLeft <= countRq(heldRq);
      coreRdInProg <= memStartRd;
    end else if (coreDataValid && wordsLeft != '0) begin
      wordsLeft <= wordsLeft - CntW'(1);
      // Last requested word has reached the core
      if (wordsLeft == CntW'(1)) begin
        coreRdInProg <= 1'b0;
      end
    end
  end

endmodule

// File: hw/memStartCtl.sv
module memStartCtl
  import mboxPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  logic     aChangeComing,
  input  logic     bChangeComing,
  input  logic     startReq,
  input  logic     rdReq,
  input  logic     wrReq,
  input  logic     forceBadPar,
  input  logic     memAcknA,
  input  logic     memAcknB,
  input  logic     nxmAckn,
  input  rqBits_t  rqIn,
  input  wordAdr_t sbusAdr,
  output logic     memStartA,
  output logic     memStartB,
  output logic     memStartRd,
  output logic     loadRq,
  output logic     lastAckn,
  output logic     memAdrPar,
  output rqBits_t  heldRq,
  output wordAdr_t heldAdr
);

  logic    memStart;
  logic    startTake;
  logic    acknPulse;
  logic    lastSeen;
  logic    clrA;
  logic    clrB;
  logic    heldRd;
  logic    heldWr;
  logic    heldBadPar;
  rqBits_t rqLeft;
  rqBits_t rqAfter;

  assign memStart = memStartA | memStartB;
  assign memStartRd = memStart & heldRd;

  // A start is taken on whichever strobe comes first while idle
  assign startTake = startReq & ~memStart & (aChangeComing | bChangeComing);

  // Acknowledges only count on the strobe of the owning phase
  assign acknPulse = ~lastSeen &
      ((memStartA & aChangeComing & (memAcknA | nxmAckn)) |
       (memStartB & bChangeComing & (memAcknB | nxmAckn)));

  // Each acknowledge retires the lowest outstanding word
  assign rqAfter = rqLeft & (rqLeft - rqBits_t'(1));
  assign lastAckn = acknPulse & (rqAfter == '0);

  assign clrA = memStartA & aChangeComing & lastSeen;
  assign clrB = memStartB & bChangeComing & lastSeen;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memStartA <= 1'b0;
      memStartB <= 1'b0;
      lastSeen <= 1'b0;
      loadRq <= 1'b0;
      rqLeft <= '0;
      heldRq <= '0;
      heldAdr <= '0;
      heldRd <= 1'b0;
      heldWr <= 1'b0;
      heldBadPar <= 1'b0;
    end else begin
      if (startTake & aChangeComing) begin
        memStartA <= 1'b1;
      end else if (clrA) begin
        memStartA <= 1'b0;
      end
      if (startTake & bChangeComing) begin
        memStartB <= 1'b1;
      end else if (clrB) begin
        memStartB <= 1'b0;
      end
      if (clrA | clrB) begin
        lastSeen <= 1'b0;
      end else if (lastAckn) begin
        lastSeen <= 1'b1;
      end
      // Held values are valid from the cycle loadRq is high
      loadRq <= startTake;
      if (startTake) begin
        rqLeft <= rqIn;
        heldRq <= rqIn;
        heldAdr <= sbusAdr;
        heldRd <= rdReq;
        heldWr <= wrReq;
        heldBadPar <= forceBadPar;
      end else if (acknPulse) begin
        rqLeft <= rqAfter;
      end
    end
  end

  // Odd parity over the held request, flipped on demand for diagnostics
  assign memAdrPar = ~(^{heldRd, heldWr, heldRq, heldAdr}) ^ heldBadPar;

endmodule

// File: hw/phaseClock.sv
`include "mbox_defines.svh"

module phaseClock
  import mboxPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  output logic      aChangeComing,
  output logic      bChangeComing,
  output busPhase_t curPhase
);

  localparam int PhaseCycles = `MBOX_PHASE_CYCLES;
  localparam int Period = 2 * PhaseCycles;
  localparam int CntW = $clog2(Period);
  localparam logic [CntW-1:0] LastA = CntW'(PhaseCycles - 1);
  localparam logic [CntW-1:0] LastB = CntW'(Period - 1);

  logic [CntW-1:0] phaseCnt;

  // Free-running count over one A+B period
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phaseCnt <= '0;
    end else if (phaseCnt == LastB) begin
      phaseCnt <= '0;
    end else begin
      phaseCnt <= phaseCnt + CntW'(1);
    end
  end

  assign curPhase = (phaseCnt <= LastA) ? PHASE_A : PHASE_B;

  // Strobes sit on the last cycle before each phase change
  assign bChangeComing = (phaseCnt == LastA);
  assign aChangeComing = (phaseCnt == LastB);

endmodule

// File: hw/mboxPkg.sv
`include "mbox_defines.svh"

package mboxPkg;

  // One request bit per word of the quad
  typedef logic [`MBOX_WORDS-1:0] rqBits_t;

  // Word index within a quad
  typedef logic [$clog2(`MBOX_WORDS)-1:0] wordAdr_t;

  // One diagnostic readback row
  typedef logic [7:0] diagWord_t;

  // Memory bus phase
  typedef enum logic {
    PHASE_A = 1'b0,
    PHASE_B = 1'b1
  } busPhase_t;

endpackage

// File: hw/mbox_defines.svh
`ifndef MBOX_DEFINES_SVH
`define MBOX_DEFINES_SVH

// Cycles per memory bus phase, a full A+B period is twice this
`define MBOX_PHASE_CYCLES 4

// Words in a quad, one request bit each
`define MBOX_WORDS 4

// Diagnostic readback rows
`define MBOX_DIAG_ROWS 8

`endif
